//--- rv_mem_geom_pkg.sv
// Geometry of the shared two-port array
package rv_mem_geom_pkg;

    // Word address width
    localparam int ADDR_WIDTH = 6;

    // Width of one stored word
    localparam int DATA_WIDTH = 32;

    // Number of words, one per address
    localparam int MEM_DEPTH = 2 ** ADDR_WIDTH;

endpackage

//--- rv_mem_pkg.sv
// Command and result format shared by every stream in the subsystem
package rv_mem_pkg;

    // Operation carried by a command and echoed in its result
    typedef enum logic {
        RV_MEM_READ  = 1'b0,
        RV_MEM_WRITE = 1'b1
    } mem_op_t;

    // Word address into the array
    typedef logic [rv_mem_geom_pkg::ADDR_WIDTH-1:0] mem_addr_t;

    // One data word
    // Read data in a read result, stored data in a write result
    typedef logic [rv_mem_geom_pkg::DATA_WIDTH-1:0] mem_data_t;

endpackage

//--- rv_seq_flow_controller.sv
`timescale 1ns/1ps

// Flow control for one sequential step with several inputs and outputs
module rv_seq_flow_controller #(
    parameter int NUM_INPUTS  = 1,
    parameter int NUM_OUTPUTS = 1
) (
    input  logic                   clk,
    input  logic                   rst,
    output logic                   enable,

    input  logic [NUM_INPUTS-1:0]  inputs_valid,
    output logic [NUM_INPUTS-1:0]  inputs_ready,
    input  logic [NUM_INPUTS-1:0]  inputs_block,

    output logic [NUM_OUTPUTS-1:0] outputs_valid,
    input  logic [NUM_OUTPUTS-1:0] outputs_ready,
    input  logic [NUM_OUTPUTS-1:0] outputs_block
);

    logic [NUM_OUTPUTS-1:0] valid_q;
    logic                   inputs_ok;
    logic                   outputs_ok;

    // Inputs not marked as blocking never hold the step back
    assign inputs_ok = &(inputs_valid | ~inputs_block);

    // Every output slot must be empty or draining this cycle
    assign outputs_ok = &(~valid_q | outputs_ready);

    assign enable        = inputs_ok && outputs_ok;
    assign inputs_ready  = {NUM_INPUTS{enable}};
    assign outputs_valid = valid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (enable) begin
            // A step refills only the outputs it actually produces
            valid_q <= outputs_block;
        end else begin
            valid_q <= valid_q & ~outputs_ready;
        end
    end

endmodule

//--- rv_memory_double_port.sv
`timescale 1ns/1ps

// Two-port storage array, read-first on both ports
module rv_memory_double_port (
    input  logic                  clk,

    input  logic                  enable0,
    input  logic                  write_enable0,
    input  rv_mem_pkg::mem_addr_t addr_in0,
    input  rv_mem_pkg::mem_data_t data_in0,
    output rv_mem_pkg::mem_data_t data_out0,

    input  logic                  enable1,
    input  logic                  write_enable1,
    input  rv_mem_pkg::mem_addr_t addr_in1,
    input  rv_mem_pkg::mem_data_t data_in1,
    output rv_mem_pkg::mem_data_t data_out1
);

    // Block RAM contents keep their value across reset
    rv_mem_pkg::mem_data_t mem [rv_mem_geom_pkg::MEM_DEPTH];

    always_ff @(posedge clk) begin
        // Port 0
        if (enable0) begin
            data_out0 <= mem[addr_in0];
            if (write_enable0) begin
                mem[addr_in0] <= data_in0;
            end
        end

        // Port 1 comes second, so it wins a same-address write collision
        if (enable1) begin
            data_out1 <= mem[addr_in1];
            if (write_enable1) begin
                mem[addr_in1] <= data_in1;
            end
        end
    end

endmodule

//--- rv_memory_double.sv
`timescale 1ns/1ps

// Single cycle two-port memory with a command and a result stream per port
// A register stage right after it lets the block RAM output register be used
module rv_memory_double #(
    parameter int WRITE_RESPOND = 0
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  cmd0_valid,
    output logic                  cmd0_ready,
    input  rv_mem_pkg::mem_op_t   cmd0_op,
    input  rv_mem_pkg::mem_addr_t cmd0_addr,
    input  rv_mem_pkg::mem_data_t cmd0_data,
    output logic                  res0_valid,
    input  logic                  res0_ready,
    output rv_mem_pkg::mem_op_t   res0_op,
    output rv_mem_pkg::mem_addr_t res0_addr,
    output rv_mem_pkg::mem_data_t res0_data,

    input  logic                  cmd1_valid,
    output logic                  cmd1_ready,
    input  rv_mem_pkg::mem_op_t   cmd1_op,
    input  rv_mem_pkg::mem_addr_t cmd1_addr,
    input  rv_mem_pkg::mem_data_t cmd1_data,
    output logic                  res1_valid,
    input  logic                  res1_ready,
    output rv_mem_pkg::mem_op_t   res1_op,
    output rv_mem_pkg::mem_addr_t res1_addr,
    output rv_mem_pkg::mem_data_t res1_data
);

    logic                  enable0;
    logic                  enable1;
    logic                  respond0;
    logic                  respond1;
    rv_mem_pkg::mem_data_t rdata0;
    rv_mem_pkg::mem_data_t rdata1;
    rv_mem_pkg::mem_data_t wdata0_q;
    rv_mem_pkg::mem_data_t wdata1_q;

    // Reads always answer, writes only when configured to
    assign respond0 = (cmd0_op == rv_mem_pkg::RV_MEM_READ) || (WRITE_RESPOND != 0);
    assign respond1 = (cmd1_op == rv_mem_pkg::RV_MEM_READ) || (WRITE_RESPOND != 0);

    rv_seq_flow_controller #(
        .NUM_INPUTS (1),
        .NUM_OUTPUTS(1)
    ) flow_controller0 (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable0),
        .inputs_valid (cmd0_valid),
        .inputs_ready (cmd0_ready),
        .inputs_block (1'b1),
        .outputs_valid(res0_valid),
        .outputs_ready(res0_ready),
        .outputs_block(respond0)
    );

    rv_seq_flow_controller #(
        .NUM_INPUTS (1),
        .NUM_OUTPUTS(1)
    ) flow_controller1 (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable1),
        .inputs_valid (cmd1_valid),
        .inputs_ready (cmd1_ready),
        .inputs_block (1'b1),
        .outputs_valid(res1_valid),
        .outputs_ready(res1_ready),
        .outputs_block(respond1)
    );

    // The array must not change while reset is held
    rv_memory_double_port mem_i (
        .clk          (clk),
        .enable0      (enable0 && !rst),
        .write_enable0(cmd0_op == rv_mem_pkg::RV_MEM_WRITE),
        .addr_in0     (cmd0_addr),
        .data_in0     (cmd0_data),
        .data_out0    (rdata0),
        .enable1      (enable1 && !rst),
        .write_enable1(cmd1_op == rv_mem_pkg::RV_MEM_WRITE),
        .addr_in1     (cmd1_addr),
        .data_in1     (cmd1_data),
        .data_out1    (rdata1)
    );

    // Result payload is captured in step with the array access
    always_ff @(posedge clk) begin
        if (enable0) begin
            res0_op   <= cmd0_op;
            res0_addr <= cmd0_addr;
            wdata0_q  <= cmd0_data;
        end
        if (enable1) begin
            res1_op   <= cmd1_op;
            res1_addr <= cmd1_addr;
            wdata1_q  <= cmd1_data;
        end
    end

    // Write results echo the stored word instead of the old one
    assign res0_data = (res0_op == rv_mem_pkg::RV_MEM_WRITE) ? wdata0_q : rdata0;
    assign res1_data = (res1_op == rv_mem_pkg::RV_MEM_WRITE) ? wdata1_q : rdata1;

endmodule

//--- rv_stream_register.sv
`timescale 1ns/1ps

// Ready/valid register stage with a two-entry skid buffer
module rv_stream_register (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  in_valid,
    output logic                  in_ready,
    input  rv_mem_pkg::mem_op_t   in_op,
    input  rv_mem_pkg::mem_addr_t in_addr,
    input  rv_mem_pkg::mem_data_t in_data,

    output logic                  out_valid,
    input  logic                  out_ready,
    output rv_mem_pkg::mem_op_t   out_op,
    output rv_mem_pkg::mem_addr_t out_addr,
    output rv_mem_pkg::mem_data_t out_data
);

    typedef enum logic [1:0] {
        EMPTY,
        ONE,
        TWO
    } state_t;

    state_t                state;
    state_t                state_next;
    logic                  push;
    logic                  pop;
    rv_mem_pkg::mem_op_t   skid_op;
    rv_mem_pkg::mem_addr_t skid_addr;
    rv_mem_pkg::mem_data_t skid_data;

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_comb begin
        state_next = state;
        case (state)
            EMPTY: begin
                if (push) begin
                    state_next = ONE;
                end
            end
            ONE: begin
                if (push && !pop) begin
                    state_next = TWO;
                end else if (!push && pop) begin
                    state_next = EMPTY;
                end
            end
            TWO: begin
                if (pop) begin
                    state_next = ONE;
                end
            end
            default: state_next = EMPTY;
        endcase
    end

    // Ready and valid come straight from flops
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= EMPTY;
            in_ready  <= 1'b1;
            out_valid <= 1'b0;
        end else begin
            state     <= state_next;
            in_ready  <= (state_next != TWO);
            out_valid <= (state_next != EMPTY);
        end
    end

    // Output entry refills from the skid entry first, then from the input
    always_ff @(posedge clk) begin
        if (state == TWO) begin
            if (pop) begin
                out_op   <= skid_op;
                out_addr <= skid_addr;
                out_data <= skid_data;
            end
        end else if (push) begin
            if (state == EMPTY || pop) begin
                out_op   <= in_op;
                out_addr <= in_addr;
                out_data <= in_data;
            end else begin
                skid_op   <= in_op;
                skid_addr <= in_addr;
                skid_data <= in_data;
            end
        end
    end

endmodule

//--- rv_dual_mem_top.sv
`timescale 1ns/1ps

// Two-port memory subsystem: input stage, memory, output stage per port
module rv_dual_mem_top #(
    parameter int WRITE_RESPOND = 0
) (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  cmd0_valid,
    output logic                  cmd0_ready,
    input  rv_mem_pkg::mem_op_t   cmd0_op,
    input  rv_mem_pkg::mem_addr_t cmd0_addr,
    input  rv_mem_pkg::mem_data_t cmd0_data,
    input  logic                  cmd1_valid,
    output logic                  cmd1_ready,
    input  rv_mem_pkg::mem_op_t   cmd1_op,
    input  rv_mem_pkg::mem_addr_t cmd1_addr,
    input  rv_mem_pkg::mem_data_t cmd1_data,

    output logic                  res0_valid,
    input  logic                  res0_ready,
    output rv_mem_pkg::mem_op_t   res0_op,
    output rv_mem_pkg::mem_addr_t res0_addr,
    output rv_mem_pkg::mem_data_t res0_data,
    output logic                  res1_valid,
    input  logic                  res1_ready,
    output rv_mem_pkg::mem_op_t   res1_op,
    output rv_mem_pkg::mem_addr_t res1_addr,
    output rv_mem_pkg::mem_data_t res1_data
);

    // Between input stages and memory
    logic                  mcmd0_valid, mcmd0_ready;
    logic                  mcmd1_valid, mcmd1_ready;
    rv_mem_pkg::mem_op_t   mcmd0_op, mcmd1_op;
    rv_mem_pkg::mem_addr_t mcmd0_addr, mcmd1_addr;
    rv_mem_pkg::mem_data_t mcmd0_data, mcmd1_data;

    // Between memory and output stages
    logic                  mres0_valid, mres0_ready;
    logic                  mres1_valid, mres1_ready;
    rv_mem_pkg::mem_op_t   mres0_op, mres1_op;
    rv_mem_pkg::mem_addr_t mres0_addr, mres1_addr;
    rv_mem_pkg::mem_data_t mres0_data, mres1_data;

    rv_stream_register cmd_in_reg_0 (
        .clk(clk), .rst(rst),
        .in_valid(cmd0_valid), .in_ready(cmd0_ready),
        .in_op(cmd0_op), .in_addr(cmd0_addr), .in_data(cmd0_data),
        .out_valid(mcmd0_valid), .out_ready(mcmd0_ready),
        .out_op(mcmd0_op), .out_addr(mcmd0_addr), .out_data(mcmd0_data)
    );

    rv_stream_register cmd_in_reg_1 (
        .clk(clk), .rst(rst),
        .in_valid(cmd1_valid), .in_ready(cmd1_ready),
        .in_op(cmd1_op), .in_addr(cmd1_addr), .in_data(cmd1_data),
        .out_valid(mcmd1_valid), .out_ready(mcmd1_ready),
        .out_op(mcmd1_op), .out_addr(mcmd1_addr), .out_data(mcmd1_data)
    );

    rv_memory_double #(
        .WRITE_RESPOND(WRITE_RESPOND)
    ) mem_i (
        .clk(clk), .rst(rst),
        .cmd0_valid(mcmd0_valid), .cmd0_ready(mcmd0_ready),
        .cmd0_op(mcmd0_op), .cmd0_addr(mcmd0_addr), .cmd0_data(mcmd0_data),
        .res0_valid(mres0_valid), .res0_ready(mres0_ready),
        .res0_op(mres0_op), .res0_addr(mres0_addr), .res0_data(mres0_data),
        .cmd1_valid(mcmd1_valid), .cmd1_ready(mcmd1_ready),
        .cmd1_op(mcmd1_op), .cmd1_addr(mcmd1_addr), .cmd1_data(mcmd1_data),
        .res1_valid(mres1_valid), .res1_ready(mres1_ready),
        .res1_op(mres1_op), .res1_addr(mres1_addr), .res1_data(mres1_data)
    );

    rv_stream_register res_out_reg_0 (
        .clk(clk), .rst(rst),
        .in_valid(mres0_valid), .in_ready(mres0_ready),
        .in_op(mres0_op), .in_addr(mres0_addr), .in_data(mres0_data),
        .out_valid(res0_valid), .out_ready(res0_ready),
        .out_op(res0_op), .out_addr(res0_addr), .out_data(res0_data)
    );

    rv_stream_register res_out_reg_1 (
        .clk(clk), .rst(rst),
        .in_valid(mres1_valid), .in_ready(mres1_ready),
        .in_op(mres1_op), .in_addr(mres1_addr), .in_data(mres1_data),
        .out_valid(res1_valid), .out_ready(res1_ready),
        .out_op(res1_op), .out_addr(res1_addr), .out_data(res1_data)
    );

endmodule

//--- rv_dual_mem_properties.sv
`timescale 1ns/1ps

// Handshake rules on the result streams of the top level
module rv_dual_mem_properties (
    input logic                  clk,
    input logic                  rst,
    input logic                  res0_valid,
    input logic                  res0_ready,
    input rv_mem_pkg::mem_op_t   res0_op,
    input rv_mem_pkg::mem_addr_t res0_addr,
    input rv_mem_pkg::mem_data_t res0_data,
    input logic                  res1_valid,
    input logic                  res1_ready,
    input rv_mem_pkg::mem_op_t   res1_op,
    input rv_mem_pkg::mem_addr_t res1_addr,
    input rv_mem_pkg::mem_data_t res1_data
);

    // Number of failed assertions
    int failures = 0;

    // A stalled result keeps valid and payload
    res0_stable: assert property (@(posedge clk) disable iff (rst)
        res0_valid && !res0_ready |=> res0_valid && $stable({res0_op, res0_addr, res0_data}))
        else begin
            $error("res0 changed while stalled");
            failures++;
        end
    res1_stable: assert property (@(posedge clk) disable iff (rst)
        res1_valid && !res1_ready |=> res1_valid && $stable({res1_op, res1_addr, res1_data}))
        else begin
            $error("res1 changed while stalled");
            failures++;
        end

    // Reset clears both result streams
    reset_quiet: assert property (@(posedge clk) rst |=> !res0_valid && !res1_valid)
        else begin
            $error("Result valid high during reset");
            failures++;
        end

    res0_known: assert property (@(posedge clk) disable iff (rst)
        res0_valid |-> !$isunknown({res0_op, res0_addr, res0_data}))
        else begin
            $error("res0 payload has X bits");
            failures++;
        end
    res1_known: assert property (@(posedge clk) disable iff (rst)
        res1_valid |-> !$isunknown({res1_op, res1_addr, res1_data}))
        else begin
            $error("res1 payload has X bits");
            failures++;
        end

endmodule

//--- rv_dual_mem_checker.sv
`timescale 1ns/1ps

// Monitor with a reference model of the array and one expected queue per port
module rv_dual_mem_checker #(
    parameter int WRITE_RESPOND = 0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  lat_check_en,
    input  logic                  cmd0_valid,
    input  logic                  cmd0_ready,
    input  rv_mem_pkg::mem_op_t   cmd0_op,
    input  rv_mem_pkg::mem_addr_t cmd0_addr,
    input  rv_mem_pkg::mem_data_t cmd0_data,
    input  logic                  cmd1_valid,
    input  logic                  cmd1_ready,
    input  rv_mem_pkg::mem_op_t   cmd1_op,
    input  rv_mem_pkg::mem_addr_t cmd1_addr,
    input  rv_mem_pkg::mem_data_t cmd1_data,
    input  logic                  mem0_valid,
    input  logic                  mem0_ready,
    input  logic                  mem1_valid,
    input  logic                  mem1_ready,
    input  logic                  res0_valid,
    input  logic                  res0_ready,
    input  rv_mem_pkg::mem_op_t   res0_op,
    input  rv_mem_pkg::mem_addr_t res0_addr,
    input  rv_mem_pkg::mem_data_t res0_data,
    input  logic                  res1_valid,
    input  logic                  res1_ready,
    input  rv_mem_pkg::mem_op_t   res1_op,
    input  rv_mem_pkg::mem_addr_t res1_addr,
    input  rv_mem_pkg::mem_data_t res1_data,
    output int                    error_count,
    output int                    outstanding
);

    typedef struct packed {
        rv_mem_pkg::mem_op_t   op;
        rv_mem_pkg::mem_addr_t addr;
        rv_mem_pkg::mem_data_t data;
    } cmd_t;

    rv_mem_pkg::mem_data_t model [rv_mem_geom_pkg::MEM_DEPTH];
    // Commands accepted at the top, waiting for the array to take them
    cmd_t                  pend0[$];
    cmd_t                  pend1[$];
    rv_mem_pkg::mem_op_t   exp_op0[$];
    rv_mem_pkg::mem_op_t   exp_op1[$];
    rv_mem_pkg::mem_addr_t exp_addr0[$];
    rv_mem_pkg::mem_addr_t exp_addr1[$];
    rv_mem_pkg::mem_data_t exp_data0[$];
    rv_mem_pkg::mem_data_t exp_data1[$];
    int                    start0[$];
    int                    start1[$];
    int                    cycle;

    initial begin
        error_count = 0;
        outstanding = 0;
        cycle       = 0;
    end

    function automatic bit responds(rv_mem_pkg::mem_op_t op);
        return (op == rv_mem_pkg::RV_MEM_READ) || (WRITE_RESPOND != 0);
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_latency(input int port, input int start);
        if (lat_check_en && (cycle - start != 3)) begin
            $display("Port %0d result took %0d cycles instead of 3", port, cycle - start);
            error_count++;
        end
    endtask

    always @(posedge clk) begin : monitor
        rv_mem_pkg::mem_data_t old0;
        rv_mem_pkg::mem_data_t old1;
        cmd_t                  c0;
        cmd_t                  c1;
        logic                  take0;
        logic                  take1;
        if (!rst) begin
            // The array takes each port's commands in the order the top accepted them
            take0 = mem0_valid && mem0_ready;
            take1 = mem1_valid && mem1_ready;
            if ((take0 && pend0.size() == 0) || (take1 && pend1.size() == 0)) begin
                $display("Memory accepted a command that was never sent");
                error_count++;
                take0 = take0 && (pend0.size() != 0);
                take1 = take1 && (pend1.size() != 0);
            end
            if (take0)
                c0 = pend0.pop_front();
            if (take1)
                c1 = pend1.pop_front();

            // Both ports read the word before either write lands
            old0 = model[c0.addr];
            old1 = model[c1.addr];
            if (take0 && responds(c0.op)) begin
                exp_op0.push_back(c0.op);
                exp_addr0.push_back(c0.addr);
                exp_data0.push_back(c0.op == rv_mem_pkg::RV_MEM_READ ? old0 : c0.data);
            end
            if (take1 && responds(c1.op)) begin
                exp_op1.push_back(c1.op);
                exp_addr1.push_back(c1.addr);
                exp_data1.push_back(c1.op == rv_mem_pkg::RV_MEM_READ ? old1 : c1.data);
            end
            // Port 1 lands last on a shared address
            if (take0 && c0.op == rv_mem_pkg::RV_MEM_WRITE)
                model[c0.addr] = c0.data;
            if (take1 && c1.op == rv_mem_pkg::RV_MEM_WRITE)
                model[c1.addr] = c1.data;

            if (cmd0_valid && cmd0_ready) begin
                pend0.push_back({cmd0_op, cmd0_addr, cmd0_data});
                if (responds(cmd0_op))
                    start0.push_back(cycle);
            end
            if (cmd1_valid && cmd1_ready) begin
                pend1.push_back({cmd1_op, cmd1_addr, cmd1_data});
                if (responds(cmd1_op))
                    start1.push_back(cycle);
            end

            if (res0_valid && res0_ready) begin
                if (exp_op0.size() == 0) begin
                    $display("Port 0 returned a result that no command asked for");
                    error_count++;
                end else begin
                    check_field("res0_op", res0_op, exp_op0.pop_front());
                    check_field("res0_addr", res0_addr, exp_addr0.pop_front());
                    check_field("res0_data", res0_data, exp_data0.pop_front());
                    check_latency(0, start0.pop_front());
                end
            end
            if (res1_valid && res1_ready) begin
                if (exp_op1.size() == 0) begin
                    $display("Port 1 returned a result that no command asked for");
                    error_count++;
                end else begin
                    check_field("res1_op", res1_op, exp_op1.pop_front());
                    check_field("res1_addr", res1_addr, exp_addr1.pop_front());
                    check_field("res1_data", res1_data, exp_data1.pop_front());
                    check_latency(1, start1.pop_front());
                end
            end
        end
        outstanding = start0.size() + start1.size();
        cycle++;
    end

    // Called once the stimulus has drained
    task automatic report_leftovers();
        if (start0.size() != 0 || start1.size() != 0) begin
            $display("Results never arrived: %0d on port 0, %0d on port 1",
                     start0.size(), start1.size());
            error_count++;
        end
    endtask

endmodule

//--- tb_rv_dual_mem.sv
`timescale 1ns/1ps

module tb_rv_dual_mem;

    localparam int NUM_ROWS       = 10;
    localparam int BURST_CMDS     = 6;
    localparam int RAND_CMDS      = 150;
    localparam int TOTAL_CMDS     = rv_mem_geom_pkg::MEM_DEPTH + 2 * NUM_ROWS
                                    + BURST_CMDS + 2 * RAND_CMDS;
    localparam int TIMEOUT_CYCLES = 20 * TOTAL_CMDS + 200;

    // Port 2 drives both ports on the same edge to the same address
    // READ there means port 0 reads while port 1 writes data
    // WRITE there means port 0 writes ~data and port 1 writes data
    typedef struct packed {
        logic [1:0]            port;
        rv_mem_pkg::mem_op_t   op;
        rv_mem_pkg::mem_addr_t addr;
        rv_mem_pkg::mem_data_t data;
        logic [7:0]            stall;
    } row_t;

    localparam row_t ROWS [NUM_ROWS] = '{
        '{2'd0, rv_mem_pkg::RV_MEM_WRITE, 6'h05, 32'h1111aaaa, 8'd0},
        '{2'd0, rv_mem_pkg::RV_MEM_READ,  6'h05, 32'h0,        8'd0},
        '{2'd0, rv_mem_pkg::RV_MEM_WRITE, 6'h10, 32'h2222bbbb, 8'd0},
        '{2'd1, rv_mem_pkg::RV_MEM_READ,  6'h10, 32'h0,        8'd0},
        '{2'd2, rv_mem_pkg::RV_MEM_READ,  6'h10, 32'h3333cccc, 8'd0},
        '{2'd1, rv_mem_pkg::RV_MEM_READ,  6'h10, 32'h0,        8'd0},
        '{2'd2, rv_mem_pkg::RV_MEM_WRITE, 6'h20, 32'h4444dddd, 8'd0},
        '{2'd0, rv_mem_pkg::RV_MEM_READ,  6'h20, 32'h0,        8'd0},
        '{2'd0, rv_mem_pkg::RV_MEM_READ,  6'h05, 32'h0,        8'd5},
        '{2'd1, rv_mem_pkg::RV_MEM_READ,  6'h20, 32'h0,        8'd3}
    };

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  lat_check_en;
    logic                  rand_done;
    logic                  cmd0_valid, cmd0_ready, cmd1_valid, cmd1_ready;
    rv_mem_pkg::mem_op_t   cmd0_op, cmd1_op, res0_op, res1_op;
    rv_mem_pkg::mem_addr_t cmd0_addr, cmd1_addr, res0_addr, res1_addr;
    rv_mem_pkg::mem_data_t cmd0_data, cmd1_data, res0_data, res1_data;
    logic                  res0_valid, res0_ready, res1_valid, res1_ready;
    int                    cycle_count = 0;

    always #4 clk = ~clk;

    rv_dual_mem_top #(.WRITE_RESPOND(0)) dut_i (.*);

    bind rv_dual_mem_top rv_dual_mem_properties props_i (.*);

    rv_dual_mem_checker #(.WRITE_RESPOND(0)) checker_i (
        .clk(clk), .rst(rst), .lat_check_en(lat_check_en),
        .cmd0_valid(cmd0_valid), .cmd0_ready(cmd0_ready), .cmd0_op(cmd0_op),
        .cmd0_addr(cmd0_addr), .cmd0_data(cmd0_data),
        .cmd1_valid(cmd1_valid), .cmd1_ready(cmd1_ready), .cmd1_op(cmd1_op),
        .cmd1_addr(cmd1_addr), .cmd1_data(cmd1_data),
        .mem0_valid(dut_i.mcmd0_valid), .mem0_ready(dut_i.mcmd0_ready),
        .mem1_valid(dut_i.mcmd1_valid), .mem1_ready(dut_i.mcmd1_ready),
        .res0_valid(res0_valid), .res0_ready(res0_ready), .res0_op(res0_op),
        .res0_addr(res0_addr), .res0_data(res0_data),
        .res1_valid(res1_valid), .res1_ready(res1_ready), .res1_op(res1_op),
        .res1_addr(res1_addr), .res1_data(res1_data),
        .error_count(), .outstanding()
    );

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Holds the command until the port takes it
    task automatic send_cmd(input int port, input rv_mem_pkg::mem_op_t op,
                            input rv_mem_pkg::mem_addr_t addr,
                            input rv_mem_pkg::mem_data_t data);
        logic accepted;
        @(negedge clk);
        if (port == 0) begin
            cmd0_valid = 1'b1;
            cmd0_op    = op;
            cmd0_addr  = addr;
            cmd0_data  = data;
        end else begin
            cmd1_valid = 1'b1;
            cmd1_op    = op;
            cmd1_addr  = addr;
            cmd1_data  = data;
        end
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            accepted = (port == 0) ? cmd0_ready : cmd1_ready;
        end
    endtask

    task automatic release_cmd(input int port);
        @(negedge clk);
        if (port == 0)
            cmd0_valid = 1'b0;
        else
            cmd1_valid = 1'b0;
    endtask

    task automatic wait_result(input int port);
        do
            @(posedge clk);
        while (!(port == 0 ? (res0_valid && res0_ready) : (res1_valid && res1_ready)));
    endtask

    task automatic apply_row(input row_t row);
        int rp;
        rp = (row.port == 2'd1) ? 1 : 0;
        @(negedge clk);
        lat_check_en = (row.stall == 0);
        if (rp == 0)
            res0_ready = (row.stall == 0);
        else
            res1_ready = (row.stall == 0);
        if (row.port == 2'd2) begin
            fork
                begin
                    send_cmd(0, row.op, row.addr, ~row.data);
                    release_cmd(0);
                end
                begin
                    send_cmd(1, rv_mem_pkg::RV_MEM_WRITE, row.addr, row.data);
                    release_cmd(1);
                end
            join
        end else begin
            send_cmd(rp, row.op, row.addr, row.data);
            release_cmd(rp);
        end
        if (row.op == rv_mem_pkg::RV_MEM_READ) begin
            repeat (row.stall) @(negedge clk);
            res0_ready = 1'b1;
            res1_ready = 1'b1;
            wait_result(rp);
        end
    endtask

    initial begin
        int drain;
        void'($urandom(32'hea9d2752));
        rst          = 1'b1;
        lat_check_en = 1'b0;
        rand_done    = 1'b0;
        cmd0_valid   = 1'b0;
        cmd1_valid   = 1'b0;
        cmd0_op      = rv_mem_pkg::RV_MEM_READ;
        cmd1_op      = rv_mem_pkg::RV_MEM_READ;
        cmd0_addr    = '0;
        cmd1_addr    = '0;
        cmd0_data    = '0;
        cmd1_data    = '0;
        res0_ready   = 1'b1;
        res1_ready   = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Known contents everywhere so reads never return X
        for (int a = 0; a < rv_mem_geom_pkg::MEM_DEPTH; a++)
            send_cmd(0, rv_mem_pkg::RV_MEM_WRITE, a, 32'h5a000000 + a * 32'h00010203);
        release_cmd(0);

        foreach (ROWS[i])
            apply_row(ROWS[i]);
        lat_check_en = 1'b0;

        // Results pile up behind a stalled output and must drain in order
        res0_ready = 1'b0;
        fork
            begin
                for (int i = 0; i < BURST_CMDS; i++)
                    send_cmd(0, rv_mem_pkg::RV_MEM_READ, 6'h30 + i, '0);
                release_cmd(0);
            end
            begin
                repeat (20) @(negedge clk);
                res0_ready = 1'b1;
            end
        join

        // Random commands on a few addresses with random back-pressure
        fork
            begin
                fork
                    begin
                        for (int i = 0; i < RAND_CMDS; i++)
                            send_cmd(0, rv_mem_pkg::mem_op_t'($urandom % 2),
                                     $urandom % 8, $urandom);
                        release_cmd(0);
                    end
                    begin
                        for (int i = 0; i < RAND_CMDS; i++)
                            send_cmd(1, rv_mem_pkg::mem_op_t'($urandom % 2),
                                     $urandom % 8, $urandom);
                        release_cmd(1);
                    end
                join
                rand_done = 1'b1;
            end
            begin
                while (!rand_done) begin
                    @(negedge clk);
                    res0_ready = ($urandom % 4) != 0;
                    res1_ready = ($urandom % 4) != 0;
                end
            end
        join

        @(negedge clk);
        res0_ready = 1'b1;
        res1_ready = 1'b1;
        drain = 0;
        while (checker_i.outstanding != 0 && drain < 100) begin
            @(posedge clk);
            drain++;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        checker_i.report_leftovers();

        $display("Checks done with %0d errors and %0d assertion failures",
                 checker_i.error_count, dut_i.props_i.failures);
        if (checker_i.error_count == 0 && dut_i.props_i.failures == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- rv_dual_mem.f
rv_mem_geom_pkg.sv
rv_mem_pkg.sv
rv_seq_flow_controller.sv
rv_memory_double_port.sv
rv_memory_double.sv
rv_stream_register.sv
rv_dual_mem_top.sv
rv_dual_mem_properties.sv
rv_dual_mem_checker.sv
tb_rv_dual_mem.sv
